/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module cornet_tb -f list.f -o cornet_sim
	./obj_dir/cornet_sim | tee sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log

/* list.f */
verilog/cornet_pkg.sv
verilog/cornet_cpu.sv
verilog/boot_rom.sv
verilog/work_ram.sv
verilog/bus_decoder.sv
verilog/cornet_top.sv
test/cornet_tb.sv

/* test/cornet_tb.sv */
// Testbench for the Cornet platform; loads each table program into the ROM and checks port writes.
`timescale 1ns/1ps
`default_nettype none

module cornet_tb
   import cornet_pkg::*;
();

   localparam int n_tests        = 5;
   localparam int max_prog       = 64;
   localparam int max_expect     = 8;
   localparam int reset_cycles   = 16;
   localparam int strobe_timeout = 1000;
   localparam int quiet_cycles   = 300;

   logic              clk;
   logic              reset_n;
   logic              rom_load_en;
   logic [rom_aw-1:0] rom_load_addr;
   logic [7:0]        rom_load_data;
   logic [7:0]        port_data;
   logic              port_strobe;

   // Each test has its program from F000, a start address and the expected port values.
   string       test_name [n_tests];
   logic [7:0]  prog      [n_tests][max_prog];
   int          prog_len  [n_tests];
   logic [15:0] start_pc  [n_tests];
   logic [7:0]  exp_val   [n_tests][max_expect];
   int          exp_len   [n_tests];

   int passed;
   int failed;

   cornet_top dut0 (
      .clk           (clk),
      .reset_n       (reset_n),
      .rom_load_en   (rom_load_en),
      .rom_load_addr (rom_load_addr),
      .rom_load_data (rom_load_data),
      .port_data     (port_data),
      .port_strobe   (port_strobe)
   );

   always #4 clk = ~clk;

   function automatic logic [15:0] here(input int t);
      return rom_base + 16'(prog_len[t]);
   endfunction

   task automatic put_byte(input int t, input logic [7:0] b);
      prog[t][prog_len[t]] = b;
      prog_len[t]++;
   endtask

   // Operands are little-endian.
   task automatic put_word(input int t, input logic [15:0] w);
      put_byte(t, w[7:0]);
      put_byte(t, w[15:8]);
   endtask

   task automatic put_store_port(input int t);
      put_byte(t, op_sta_abs);
      put_word(t, port_addr);
   endtask

   // Every program ends in a jump to itself.
   task automatic put_park(input int t);
      logic [15:0] self_addr;
      self_addr = here(t);
      put_byte(t, op_jmp_abs);
      put_word(t, self_addr);
   endtask

   task automatic add_expected(input int t, input logic [7:0] v);
      exp_val[t][exp_len[t]] = v;
      exp_len[t]++;
   endtask

   task automatic build_table();
      logic [7:0]  d;
      logic [7:0]  x;
      logic [15:0] a [3];
      logic [15:0] addr;
      for (int t = 0; t < n_tests; t++) begin
         prog_len[t] = 0;
         exp_len[t]  = 0;
         start_pc[t] = rom_base;
      end

      // A decoy store at F000 would put the inverted value on the port.
      test_name[0] = "reset vector";
      d = 8'($urandom());
      put_byte(0, op_lda_imm);
      put_byte(0, ~d);
      put_store_port(0);
      start_pc[0] = here(0);
      put_byte(0, op_lda_imm);
      put_byte(0, d);
      put_store_port(0);
      put_park(0);
      add_expected(0, d);

      test_name[1] = "ram round trip";
      x = 8'(1 + $urandom() % 15);
      for (int i = 0; i < 3; i++) begin
         d = 8'($urandom());
         a[i] = 16'h0010 + 16'(i * 512) + 16'($urandom() % 32'h1f0);
         put_byte(1, op_lda_imm);
         put_byte(1, d);
         put_byte(1, op_sta_abs);
         put_word(1, a[i]);
         add_expected(1, d);
      end
      put_byte(1, op_ldx_imm);
      put_byte(1, x);
      for (int i = 0; i < 3; i++) begin
         put_byte(1, op_lda_absx);
         put_word(1, a[i] - {8'h00, x});
         put_store_port(1);
      end
      put_park(1);

      test_name[2] = "jmp skip";
      d = 8'($urandom());
      put_byte(2, op_lda_imm);
      put_byte(2, d);
      put_store_port(2);
      add_expected(2, d);
      // Target lies past JMP (3), LDA # (2) and STA (3).
      addr = here(2) + 16'd8;
      put_byte(2, op_jmp_abs);
      put_word(2, addr);
      put_byte(2, op_lda_imm);
      put_byte(2, ~d);
      put_store_port(2);
      d = 8'($urandom());
      put_byte(2, op_lda_imm);
      put_byte(2, d);
      put_store_port(2);
      add_expected(2, d);
      put_park(2);

      test_name[3] = "counting loop";
      addr = 16'($urandom() % 32'h700);
      for (int i = 0; i < 5; i++) begin
         d = 8'($urandom());
         put_byte(3, op_lda_imm);
         put_byte(3, d);
         put_byte(3, op_sta_abs);
         put_word(3, addr + 16'h00fb + 16'(i));
         add_expected(3, d);
      end
      put_byte(3, op_ldx_imm);
      put_byte(3, 8'hfb);
      a[0] = here(3);
      put_byte(3, op_lda_absx);
      put_word(3, addr);
      put_store_port(3);
      put_byte(3, op_inx);
      put_byte(3, op_bne);
      put_byte(3, 8'(a[0] - here(3) - 16'd1));
      put_park(3);

      test_name[4] = "unmapped read, undefined opcode";
      addr = 16'h1000 + 16'($urandom() % 32'h8000);
      put_byte(4, op_ldx_imm);
      put_byte(4, 8'h00);
      put_byte(4, op_lda_absx);
      put_word(4, addr);
      put_store_port(4);
      add_expected(4, unmapped_data);
      // If 1A were taken as two bytes, the immediate below would run as an opcode.
      put_byte(4, 8'h1a);
      d = 8'($urandom());
      put_byte(4, op_lda_imm);
      put_byte(4, d);
      put_store_port(4);
      add_expected(4, d);
      put_park(4);
   endtask

   task automatic load_byte(input logic [rom_aw-1:0] addr, input logic [7:0] data);
      rom_load_en   = 1'b1;
      rom_load_addr = addr;
      rom_load_data = data;
      @(negedge clk);
   endtask

   task automatic wait_strobe(output bit seen);
      int cycles;
      seen   = 1'b0;
      cycles = 0;
      while (!seen && cycles < strobe_timeout) begin
         @(negedge clk);
         cycles++;
         if (port_strobe) seen = 1'b1;
      end
   endtask

   task automatic count_strobes(input int cycles, output int n);
      n = 0;
      for (int i = 0; i < cycles; i++) begin
         @(negedge clk);
         if (port_strobe) n++;
      end
   endtask

   task automatic run_test(input int t);
      int test_errors;
      int extra;
      bit seen;
      test_errors = 0;
      @(negedge clk);
      reset_n = 1'b0;
      repeat (reset_cycles) @(negedge clk);
      for (int i = 0; i < prog_len[t]; i++) begin
         load_byte(12'(i), prog[t][i]);
      end
      load_byte(reset_vector[rom_aw-1:0], start_pc[t][7:0]);
      load_byte(reset_vector[rom_aw-1:0] + 12'd1, start_pc[t][15:8]);
      rom_load_en = 1'b0;
      @(negedge clk);
      reset_n = 1'b1;
      for (int k = 0; k < exp_len[t]; k++) begin
         wait_strobe(seen);
         if (!seen) begin
            $display("Test %0d: no port write %0d of %0d within %0d cycles",
                     t, k + 1, exp_len[t], strobe_timeout);
            test_errors++;
            break;
         end
         if (port_data !== exp_val[t][k]) begin
            $display("ERR time %0t: port_data expected %02h, actual %02h",
                     $time, exp_val[t][k], port_data);
            test_errors++;
         end
      end
      if (test_errors == 0) begin
         count_strobes(quiet_cycles, extra);
         if (extra != 0) begin
            $display("Test %0d: %0d port writes arrived after the expected ones", t, extra);
            test_errors++;
         end
      end
      if (test_errors == 0) begin
         passed++;
         $display("Test %0d (%s): PASS", t, test_name[t]);
      end else begin
         failed++;
         $display("Test %0d (%s): FAIL with %0d errors", t, test_name[t], test_errors);
      end
   endtask

   initial begin
      clk           = 1'b0;
      reset_n       = 1'b0;
      rom_load_en   = 1'b0;
      rom_load_addr = '0;
      rom_load_data = 8'h00;
      passed        = 0;
      failed        = 0;
      void'($urandom(32'h21cf_f139));
      build_table();
      for (int t = 0; t < n_tests; t++) begin
         run_test(t);
      end
      $display("Tests run: %0d, passed: %0d, failed: %0d", n_tests, passed, failed);
      if (failed == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* verilog/boot_rom.sv */
// Boot ROM holding the program and reset vector; loaded through its port while reset is held.
`timescale 1ns/1ps
`default_nettype none

module boot_rom
   import cornet_pkg::*;
(
   input  logic              clk,
   input  logic              reset_n,
   input  logic              sel,
   input  bus_req_t          bus_req,
   output mem_rsp_t          rsp,
   input  logic              load_en,
   input  logic [rom_aw-1:0] load_addr,
   input  logic [7:0]        load_data
);

   logic [7:0]        mem [rom_words];
   logic [rom_aw-1:0] index;

   assign index = bus_req.addr[rom_aw-1:0];

   // Bus writes never reach the array, so stores into ROM space are dropped.
   always_ff @(posedge clk) begin
      if (!reset_n && load_en) begin
         mem[load_addr] <= load_data;
      end
      if (sel && bus_req.rd_req && !rsp.rd_ack) begin
         rsp.rd_data <= mem[index];
      end
      if (!reset_n) begin
         rsp.rd_ack <= 1'b0;
      end else begin
         rsp.rd_ack <= sel && bus_req.rd_req && !rsp.rd_ack;
      end
   end

   // The loader must finish before the CPU comes out of reset.
   a_load_in_reset: assert property (@(posedge clk) reset_n |-> !load_en);

endmodule

`default_nettype wire

/* verilog/bus_decoder.sv */
// Address decoder between the CPU and memories; merges read responses and owns the output port.
`timescale 1ns/1ps
`default_nettype none

module bus_decoder
   import cornet_pkg::*;
(
   input  logic       clk,
   input  logic       reset_n,
   input  bus_req_t   cpu_req,
   output bus_rsp_t   cpu_rsp,
   output logic       rom_sel,
   output logic       ram_sel,
   input  mem_rsp_t   rom_rsp,
   input  mem_rsp_t   ram_rsp,
   output logic [7:0] port_data,
   output logic       port_strobe
);

   logic unmapped_ack;
   logic port_hit;

   assign rom_sel  = (cpu_req.addr[15:rom_aw] == rom_base[15:rom_aw]);
   assign ram_sel  = (cpu_req.addr[15:ram_aw] == ram_base[15:ram_aw]);
   assign port_hit = (cpu_req.addr == port_addr);

   // Reads outside both memories, the port included, are answered here.
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         unmapped_ack <= 1'b0;
      end else begin
         unmapped_ack <= cpu_req.rd_req && !rom_sel && !ram_sel && !unmapped_ack;
      end
   end

   // addr is held until the ack, so the current region picks the response.
   always_comb begin
      if (rom_sel) begin
         cpu_rsp.rd_data = rom_rsp.rd_data;
         cpu_rsp.rd_ack  = rom_rsp.rd_ack;
      end else if (ram_sel) begin
         cpu_rsp.rd_data = ram_rsp.rd_data;
         cpu_rsp.rd_ack  = ram_rsp.rd_ack;
      end else begin
         cpu_rsp.rd_data = unmapped_data;
         cpu_rsp.rd_ack  = unmapped_ack;
      end
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         port_data   <= 8'h00;
         port_strobe <= 1'b0;
      end else begin
         port_strobe <= cpu_req.wr_en && port_hit;
         if (cpu_req.wr_en && port_hit) begin
            port_data <= cpu_req.wr_data;
         end
      end
   end

   // The regions do not overlap, so two memories never answer at once.
   a_one_ack: assert property (@(posedge clk) disable iff (!reset_n)
      !(rom_rsp.rd_ack && ram_rsp.rd_ack));

endmodule

`default_nettype wire

/* verilog/cornet_cpu.sv */
// Minimal 6502-style CPU for bus bring-up; boots from the reset vector and runs seven opcodes.
`timescale 1ns/1ps
`default_nettype none

module cornet_cpu
   import cornet_pkg::*;
(
   input  logic     clk,
   input  logic     reset_n,
   output bus_req_t bus_req,
   input  bus_rsp_t bus_rsp
);

   typedef enum logic [2:0] {
      F_RESET, F_BOOT, F_VECTOR, F_FETCH, F_OPCODE, F_EXEC
   } fetch_state_t;

   typedef enum logic [1:0] {D_IDLE, D_OPERAND, D_DATA} dec_state_t;

   typedef enum logic [1:0] {B_IDLE, B_LOW, B_GAP, B_HIGH} bus_state_t;

   typedef enum logic [1:0] {ACC_BYTE, ACC_WORD, ACC_WRITE} acc_kind_t;

   fetch_state_t fetch_state;
   dec_state_t   dec_state;
   bus_state_t   bus_state;

   logic [15:0] pc;
   logic [15:0] pc_next;
   logic [7:0]  ir;
   logic [7:0]  reg_a;
   logic [7:0]  reg_x;
   logic        flag_z;

   logic        fetch_start;
   logic        fetch_word;
   logic [15:0] fetch_addr;
   logic        dec_go;
   logic        dec_start;
   acc_kind_t   dec_kind;
   logic [15:0] dec_addr;
   logic        exe_go;
   logic        exe_done;

   logic        acc_start;
   acc_kind_t   acc_kind;
   logic [15:0] acc_addr;
   logic        acc_done;
   logic        acc_word_mode;
   logic [15:0] acc_word;

   // Fetch and decode take turns driving the access machine.
   assign acc_start = fetch_start | dec_start;
   assign acc_kind  = fetch_start ? (fetch_word ? ACC_WORD : ACC_BYTE) : dec_kind;
   assign acc_addr  = fetch_start ? fetch_addr : dec_addr;

   // Fetch machine. Two idle cycles after reset, then the vector, then the opcode loop.
   always_ff @(posedge clk) begin
      fetch_start <= 1'b0;
      dec_go      <= 1'b0;
      if (!reset_n) begin
         fetch_state <= F_RESET;
      end else begin
         case (fetch_state)
            F_RESET: fetch_state <= F_BOOT;
            F_BOOT: begin
               fetch_start <= 1'b1;
               fetch_word  <= 1'b1;
               fetch_addr  <= reset_vector;
               fetch_state <= F_VECTOR;
            end
            F_VECTOR: if (acc_done) begin
               pc          <= acc_word;
               fetch_state <= F_FETCH;
            end
            F_FETCH: begin
               fetch_start <= 1'b1;
               fetch_word  <= 1'b0;
               fetch_addr  <= pc;
               fetch_state <= F_OPCODE;
            end
            F_OPCODE: if (acc_done) begin
               ir          <= acc_word[7:0];
               dec_go      <= 1'b1;
               fetch_state <= F_EXEC;
            end
            F_EXEC: if (exe_done) begin
               pc          <= pc_next;
               fetch_state <= F_FETCH;
            end
            default: fetch_state <= F_RESET;
         endcase
      end
   end

   // Decode machine. Reads the operand, then does the data access for LDA abs,X and STA.
   always_ff @(posedge clk) begin
      dec_start <= 1'b0;
      exe_go    <= 1'b0;
      if (!reset_n) begin
         dec_state <= D_IDLE;
      end else begin
         case (dec_state)
            D_IDLE: if (dec_go) begin
               dec_addr <= pc + 16'd1;
               case (ir)
                  op_lda_imm, op_ldx_imm, op_bne: begin
                     dec_start <= 1'b1;
                     dec_kind  <= ACC_BYTE;
                     dec_state <= D_OPERAND;
                  end
                  op_lda_absx, op_sta_abs, op_jmp_abs: begin
                     dec_start <= 1'b1;
                     dec_kind  <= ACC_WORD;
                     dec_state <= D_OPERAND;
                  end
                  default: exe_go <= 1'b1;
               endcase
            end
            D_OPERAND: if (acc_done) begin
               if (ir == op_lda_absx) begin
                  dec_start <= 1'b1;
                  dec_kind  <= ACC_BYTE;
                  dec_addr  <= acc_word + {8'h00, reg_x};
                  dec_state <= D_DATA;
               end else if (ir == op_sta_abs) begin
                  dec_start <= 1'b1;
                  dec_kind  <= ACC_WRITE;
                  dec_addr  <= acc_word;
                  dec_state <= D_DATA;
               end else begin
                  exe_go    <= 1'b1;
                  dec_state <= D_IDLE;
               end
            end
            D_DATA: if (acc_done) begin
               exe_go    <= 1'b1;
               dec_state <= D_IDLE;
            end
            default: dec_state <= D_IDLE;
         endcase
      end
   end

   // Execute machine. The last byte read sits in acc_word[7:0].
   always_ff @(posedge clk) begin
      exe_done <= 1'b0;
      if (!reset_n) begin
         reg_a  <= 8'h00;
         reg_x  <= 8'h00;
         flag_z <= 1'b0;
      end else if (exe_go) begin
         exe_done <= 1'b1;
         case (ir)
            op_lda_imm, op_lda_absx: begin
               reg_a   <= acc_word[7:0];
               flag_z  <= (acc_word[7:0] == 8'h00);
               pc_next <= (ir == op_lda_imm) ? pc + 16'd2 : pc + 16'd3;
            end
            op_ldx_imm: begin
               reg_x   <= acc_word[7:0];
               flag_z  <= (acc_word[7:0] == 8'h00);
               pc_next <= pc + 16'd2;
            end
            op_inx: begin
               reg_x   <= reg_x + 8'd1;
               flag_z  <= (reg_x == 8'hff);
               pc_next <= pc + 16'd1;
            end
            op_sta_abs: pc_next <= pc + 16'd3;
            op_jmp_abs: pc_next <= acc_word;
            // Offset is relative to the byte after BNE.
            op_bne: pc_next <= flag_z ? pc + 16'd2
                                      : pc + 16'd2 + {{8{acc_word[7]}}, acc_word[7:0]};
            default: pc_next <= pc + 16'd1;
         endcase
      end
   end

   // Bus-access machine. A word is two byte reads with rd_req dropped between them.
   always_ff @(posedge clk) begin
      acc_done      <= 1'b0;
      bus_req.wr_en <= 1'b0;
      if (!reset_n) begin
         bus_state      <= B_IDLE;
         bus_req.rd_req <= 1'b0;
      end else begin
         case (bus_state)
            B_IDLE: if (acc_start) begin
               bus_req.addr <= acc_addr;
               if (acc_kind == ACC_WRITE) begin
                  bus_req.wr_en   <= 1'b1;
                  bus_req.wr_data <= reg_a;
                  acc_done        <= 1'b1;
               end else begin
                  bus_req.rd_req <= 1'b1;
                  acc_word_mode  <= (acc_kind == ACC_WORD);
                  bus_state      <= B_LOW;
               end
            end
            B_LOW: if (bus_rsp.rd_ack) begin
               bus_req.rd_req <= 1'b0;
               acc_word[7:0]  <= bus_rsp.rd_data;
               if (acc_word_mode) begin
                  bus_req.addr <= bus_req.addr + 16'd1;
                  bus_state    <= B_GAP;
               end else begin
                  acc_done  <= 1'b1;
                  bus_state <= B_IDLE;
               end
            end
            B_GAP: begin
               bus_req.rd_req <= 1'b1;
               bus_state      <= B_HIGH;
            end
            B_HIGH: if (bus_rsp.rd_ack) begin
               bus_req.rd_req <= 1'b0;
               acc_word[15:8] <= bus_rsp.rd_data;
               acc_done       <= 1'b1;
               bus_state      <= B_IDLE;
            end
            default: bus_state <= B_IDLE;
         endcase
      end
   end

   // Only one access is ever in flight.
   a_no_rd_wr: assert property (@(posedge clk) disable iff (!reset_n)
      !(bus_req.rd_req && bus_req.wr_en));

   // A pending read holds its request and address until the responder answers.
   a_rd_hold: assert property (@(posedge clk) disable iff (!reset_n)
      bus_req.rd_req && !bus_rsp.rd_ack |=> bus_req.rd_req && $stable(bus_req.addr));

endmodule

`default_nettype wire

/* verilog/cornet_pkg.sv */
// Memory map, opcodes and bus structs of the Cornet test platform, imported by every RTL module.
`default_nettype none

package cornet_pkg;

   // Work RAM sits at the bottom of the address space.
   localparam logic [15:0] ram_base  = 16'h0000;
   localparam int          ram_words = 2048;
   localparam int          ram_aw    = $clog2(ram_words);

   // Boot ROM fills the top 4 KiB, so it also holds the reset vector.
   localparam logic [15:0] rom_base  = 16'hf000;
   localparam int          rom_words = 4096;
   localparam int          rom_aw    = $clog2(rom_words);

   localparam logic [15:0] port_addr     = 16'hd000;
   localparam logic [15:0] reset_vector  = 16'hfffc;
   localparam logic [7:0]  unmapped_data = 8'hff;

   // The seven opcodes the CPU knows. Anything else is a one-byte no-op.
   localparam logic [7:0] op_lda_imm  = 8'ha9;
   localparam logic [7:0] op_ldx_imm  = 8'ha2;
   localparam logic [7:0] op_lda_absx = 8'hbd;
   localparam logic [7:0] op_sta_abs  = 8'h8d;
   localparam logic [7:0] op_inx      = 8'he8;
   localparam logic [7:0] op_jmp_abs  = 8'h4c;
   localparam logic [7:0] op_bne      = 8'hd0;

   // Request from the CPU. rd_req is a level, wr_en a one-cycle strobe.
   typedef struct packed {
      logic [15:0] addr;
      logic [7:0]  wr_data;
      logic        wr_en;
      logic        rd_req;
   } bus_req_t;

   // Merged read response returned to the CPU.
   typedef struct packed {
      logic [7:0] rd_data;
      logic       rd_ack;
   } bus_rsp_t;

   // Response of a single memory before the decoder picks one.
   typedef struct packed {
      logic [7:0] rd_data;
      logic       rd_ack;
   } mem_rsp_t;

endpackage

`default_nettype wire

/* verilog/cornet_top.sv */
// Top level of the Cornet test platform; the CPU, boot ROM, work RAM and decoder on one bus.
`timescale 1ns/1ps
`default_nettype none

module cornet_top
   import cornet_pkg::*;
(
   input  logic              clk,
   input  logic              reset_n,
   input  logic              rom_load_en,
   input  logic [rom_aw-1:0] rom_load_addr,
   input  logic [7:0]        rom_load_data,
   output logic [7:0]        port_data,
   output logic              port_strobe
);

   bus_req_t cpu_req;
   bus_rsp_t cpu_rsp;
   mem_rsp_t rom_rsp;
   mem_rsp_t ram_rsp;
   logic     rom_sel;
   logic     ram_sel;

   cornet_cpu cpu0 (
      .clk     (clk),
      .reset_n (reset_n),
      .bus_req (cpu_req),
      .bus_rsp (cpu_rsp)
   );

   // Both memories see every request and act only when selected.
   boot_rom rom0 (
      .clk       (clk),
      .reset_n   (reset_n),
      .sel       (rom_sel),
      .bus_req   (cpu_req),
      .rsp       (rom_rsp),
      .load_en   (rom_load_en),
      .load_addr (rom_load_addr),
      .load_data (rom_load_data)
   );

   work_ram ram0 (
      .clk     (clk),
      .reset_n (reset_n),
      .sel     (ram_sel),
      .bus_req (cpu_req),
      .rsp     (ram_rsp)
   );

   bus_decoder decoder0 (
      .clk         (clk),
      .reset_n     (reset_n),
      .cpu_req     (cpu_req),
      .cpu_rsp     (cpu_rsp),
      .rom_sel     (rom_sel),
      .ram_sel     (ram_sel),
      .rom_rsp     (rom_rsp),
      .ram_rsp     (ram_rsp),
      .port_data   (port_data),
      .port_strobe (port_strobe)
   );

endmodule

`default_nettype wire

/* verilog/work_ram.sv */
// Work RAM for CPU data; answers selected reads one cycle later and takes selected writes.
`timescale 1ns/1ps
`default_nettype none

module work_ram
   import cornet_pkg::*;
(
   input  logic     clk,
   input  logic     reset_n,
   input  logic     sel,
   input  bus_req_t bus_req,
   output mem_rsp_t rsp
);

   logic [7:0]        mem [ram_words];
   logic [ram_aw-1:0] index;
   logic              wr_hit;
   logic              rd_hit;

   assign index  = bus_req.addr[ram_aw-1:0];
   assign wr_hit = sel && bus_req.wr_en;

   // A read is answered once, even if rd_req lingers for a cycle after the ack.
   assign rd_hit = sel && bus_req.rd_req && !rsp.rd_ack;

   always_ff @(posedge clk) begin
      if (wr_hit) begin
         mem[index] <= bus_req.wr_data;
      end
      if (rd_hit) begin
         rsp.rd_data <= mem[index];
      end
      if (!reset_n) begin
         rsp.rd_ack <= 1'b0;
      end else begin
         rsp.rd_ack <= rd_hit;
      end
   end

endmodule

`default_nettype wire
